/* run.sh */
#!/bin/sh
# Build and run the scopeController testbench with Verilator.
# Exit status is non-zero when the build, the run or the regression fails.

verilator --binary --timing --assert -Wno-fatal -j 0 --top-module scopeControllerTb \
	-f sim.f --Mdir obj_dir -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
	echo "simulation exited with status $runStatus"
	exit 1
fi

if grep -q "Regression failed" sim.log; then
	exit 1
fi
exit 0

/* sim.f */
verilog/cmdPkg.sv
verilog/cfgPkg.sv
verilog/cmdReceiver.sv
verilog/scopeConfigRegs.sv
verilog/offsetPwm.sv
verilog/tdcReply.sv
verilog/scopeController.sv
verification/tbClock.sv
verification/scopeControllerTb.sv

/* verification/scopeControllerTb.sv */
// directed checks for ramWidth 12 and pwmPrescale 2; the DUT is expected to become board 0 early on
`timescale 1ns/1ps

module scopeControllerTb;
	import cmdPkg::*;
	import cfgPkg::*;

	localparam int ramWidth = 12;
	localparam int pwmPrescale = 2;
	localparam int pwmWindow = 256 * (pwmPrescale + 1); // one full PWM period
	localparam logic [7:0] delayValue = 8'h3C; // fixed TDC results
	localparam logic [7:0] carryValue = 8'hA7;

	logic clk;
	logic rstN;
	logic rxReady;
	cmdByte_t rxData;
	logic txBusy;
	logic [7:0] delayCounter;
	logic [7:0] carryCounter;
	logic txStart;
	cmdByte_t txData;
	cmdByte_t comData;
	logic newComData;
	scopeCfg_t cfg;
	logic [ramWidth-1:0] triggerPoint;
	logic [ramWidth:0] triggerTot;
	logic armTrigger;
	logic [3:0] offset;

	scopeCfg_t model; // expected configuration
	cmdByte_t fwdQ[$]; // bytes sent down the chain
	cmdByte_t txQ[$]; // bytes handed to the UART
	int armCount = 0;
	int mismatchErrors = 0;
	int otherErrors = 0;
	int seedValue;

	tbClock clockGen (.clk(clk), .rstN(rstN));

	scopeController #(.ramWidth(ramWidth), .pwmPrescale(pwmPrescale)) scopeController_inst (
		.clk(clk), .rstN(rstN), .rxReady(rxReady), .rxData(rxData), .txBusy(txBusy),
		.delayCounter(delayCounter), .carryCounter(carryCounter), .txStart(txStart),
		.txData(txData), .comData(comData), .newComData(newComData), .cfg(cfg),
		.triggerPoint(triggerPoint), .triggerTot(triggerTot), .armTrigger(armTrigger),
		.offset(offset)
	);

	// output monitors, sampled before the edge updates them
	always @(posedge clk) begin
		if (rstN && newComData) fwdQ.push_back(comData);
		if (rstN && txStart) txQ.push_back(txData);
		if (rstN && armTrigger) armCount++;
	end

	task automatic checkCfg(string name, scopeCfg_t expected, scopeCfg_t actual);
		if (expected !== actual) begin
			mismatchErrors++;
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic checkByte(string name, cmdByte_t expected, cmdByte_t actual);
		if (expected !== actual) begin
			mismatchErrors++;
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic checkPoint(string name, logic [ramWidth-1:0] expected,
		logic [ramWidth-1:0] actual);
		if (expected !== actual) begin
			mismatchErrors++;
			$display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic checkCount(string name, int expected, int actual);
		if (expected != actual) begin
			mismatchErrors++;
			$display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	// trigger point window 4 .. depth-16
	function automatic logic [ramWidth-1:0] clampPoint(int raw);
		int hi;
		hi = (1 << ramWidth) - 16;
		if (raw > hi) return ramWidth'(hi);
		if (raw < 4) return ramWidth'(4);
		return ramWidth'(raw);
	endfunction

	task automatic sendByte(cmdByte_t value);
		@(posedge clk);
		rxReady <= 1'b1;
		rxData <= value;
		@(posedge clk);
		rxReady <= 1'b0;
		repeat (3) @(posedge clk); // keeps the UART byte spacing
	endtask

	task automatic settle();
		repeat (6) @(posedge clk); // longest path is 3 cycles
		@(negedge clk);
	endtask

	task automatic expectFwd(string name, cmdByte_t expected);
		int waited = 0;
		while (fwdQ.size() == 0 && waited < 20) begin
			@(negedge clk);
			waited++;
		end
		if (fwdQ.size() == 0) begin
			otherErrors++;
			$display("%s: no byte was forwarded within 20 cycles", name);
		end else begin
			checkByte(name, expected, fwdQ.pop_front());
		end
	endtask

	// every byte of a command goes down the chain in order
	task automatic sendCommand(string name, cmdByte_t op, int argCount, cmdByte_t arg0,
		cmdByte_t arg1);
		sendByte(op);
		if (argCount > 0) sendByte(arg0);
		if (argCount > 1) sendByte(arg1);
		settle();
		expectFwd({name, " opcode"}, op);
		if (argCount > 0) expectFwd({name, " arg0"}, arg0);
		if (argCount > 1) expectFwd({name, " arg1"}, arg1);
		checkCount({name, " extra forwards"}, 0, fwdQ.size());
		fwdQ.delete();
	endtask

	task automatic idAssignment();
		checkCfg("reset cfg", model, cfg);
		checkCount("reset newComData", 0, newComData);
		checkCount("reset txStart", 0, txStart);
		checkCount("reset armTrigger", 0, armTrigger);
		sendByte(8'd3);
		settle();
		model.boardId = 8'd3;
		model.masterClock = 2'b01; // nonzero id is a clock slave
		checkCfg("id 3", model, cfg);
		expectFwd("id 3 forward", 8'd4);
		sendByte(8'd0);
		settle();
		model.boardId = 8'd0;
		model.masterClock = 2'b00;
		checkCfg("id 0", model, cfg);
		expectFwd("id 0 forward", 8'd1);
		checkCount("id extra forwards", 0, fwdQ.size());
	endtask

	task automatic argumentCommands();
		cmdByte_t thresh;
		cmdByte_t thresh2;
		thresh = 8'($urandom);
		thresh2 = 8'($urandom);
		sendCommand("trig point high", opSetTrigPoint, 2, 8'h0F, 8'hFF);
		checkPoint("trig point high", clampPoint(16'h0FFF), triggerPoint);
		sendCommand("trig point low", opSetTrigPoint, 2, 8'h00, 8'h01);
		checkPoint("trig point low", clampPoint(16'h0001), triggerPoint);
		sendCommand("downsample", opDownsample, 1, 8'd40, 8'd0);
		model.downsample = 5'd30; // clamped
		sendCommand("threshold", opTrigThresh, 1, thresh, 8'd0);
		model.trigThresh = thresh;
		sendCommand("high threshold", opTrigThresh2, 1, thresh2, 8'd0);
		model.trigThresh2 = thresh2;
		sendCommand("trig type", opTrigType, 1, 8'h05, 8'd0);
		model.triggerType = 4'h5;
		sendCommand("trig tot", opTrigTot, 2, 8'h01, 8'h23);
		checkCount("trig tot", 'h123, triggerTot);
		checkCfg("argument cfg", model, cfg);
	endtask

	task automatic channelToggles();
		sendCommand("trig chan mine", opTrigChan, 1, 8'h02, 8'd0); // board 0 chan 2
		model.trigChannels[2] = ~model.trigChannels[2];
		checkCfg("trig chan mine", model, cfg);
		sendCommand("trig chan other", opTrigChan, 1, 8'h06, 8'd0); // board 1 chan 2
		checkCfg("trig chan other", model, cfg);
		sendCommand("gain sw", opGainSw, 1, 8'h01, 8'd0);
		model.gainSw[1] = ~model.gainSw[1];
		checkCfg("gain sw", model, cfg);
	endtask

	task automatic pwmDuty();
		int highCount[4];
		sendCommand("pwm level", opPwmLevel, 2, 8'h01, 8'd100);
		for (int c = 0; c < 4; c++) highCount[c] = 0;
		repeat (pwmWindow) begin
			@(negedge clk);
			for (int c = 0; c < 4; c++) if (offset[c]) highCount[c]++;
		end
		for (int c = 0; c < 4; c++) begin
			checkCount($sformatf("pwm duty ch%0d", c), ((c == 1) ? 100 : 58) * (pwmPrescale + 1),
				highCount[c]);
		end
	endtask

	// one TDC byte while the UART stays busy for a random time
	task automatic tdcRead(string name, cmdByte_t op, cmdByte_t expected);
		int hold;
		int waited = 0;
		hold = 4 + ($urandom % 30);
		@(posedge clk);
		txBusy <= 1'b1;
		sendByte(op);
		repeat (hold) @(posedge clk);
		@(negedge clk);
		checkCount({name, " txStart while busy"}, 0, txQ.size());
		@(posedge clk);
		txBusy <= 1'b0;
		while (txQ.size() == 0 && waited < 40) begin
			@(negedge clk);
			waited++;
		end
		if (txQ.size() == 0) begin
			otherErrors++;
			$display("%s: txStart never came after txBusy dropped", name);
		end
		settle();
		checkCount({name, " txStart count"}, 1, txQ.size());
		if (txQ.size() > 0) checkByte(name, expected, txQ[0]);
		txQ.delete();
		checkCount({name, " forwards"}, 0, fwdQ.size());
	endtask

	task automatic tdcReadout();
		sendCommand("select other", selectBase + 8'd1, 0, 8'd0, 8'd0);
		model.serialPassthrough = 1'b1;
		checkCfg("select other", model, cfg);
		sendCommand("delay passthrough", opDelayCnt, 0, 8'd0, 8'd0);
		checkCount("passthrough txStart", 0, txQ.size());
		sendByte(selectBase + model.boardId); // this board answers again
		settle();
		model.serialPassthrough = 1'b0;
		checkCfg("select mine", model, cfg);
		checkCount("select mine forwards", 0, fwdQ.size());
		tdcRead("delay counter", opDelayCnt, delayValue);
		tdcRead("carry counter", opCarryCnt, carryValue);
	endtask

	task automatic chainControl();
		sendCommand("arm", opArm, 0, 8'd0, 8'd0);
		checkCount("arm pulses", 1, armCount);
		sendCommand("roll off", opRollOff, 0, 8'd0, 8'd0);
		model.rollingTrigger = 1'b0;
		checkCfg("roll off", model, cfg);
		sendCommand("roll on", opRollOn, 0, 8'd0, 8'd0);
		model.rollingTrigger = 1'b1;
		checkCfg("roll on", model, cfg);
		sendCommand("last mine", lastBase + model.boardId, 0, 8'd0, 8'd0);
		model.imTheLast = 1'b1;
		checkCfg("last mine", model, cfg);
		sendCommand("last other", lastBase + model.boardId + 8'd1, 0, 8'd0, 8'd0);
		model.imTheLast = 1'b0;
		checkCfg("last other", model, cfg);
		sendByte(8'd200); // unknown opcode
		settle();
		checkCount("unknown forwards", 0, fwdQ.size());
		checkCfg("unknown", model, cfg);
	endtask

	initial begin
		seedValue = $urandom(88);
		rxReady <= 1'b0;
		rxData <= '0;
		txBusy <= 1'b0;
		delayCounter <= delayValue;
		carryCounter <= carryValue;
		model = '{boardId: 8'd200, masterClock: 2'b00, imTheLast: 1'b0,
			serialPassthrough: 1'b0, rollingTrigger: 1'b1, trigThresh: 8'h80,
			trigThresh2: 8'hFF, triggerType: 4'b0001, trigChannels: 4'b1111,
			gainSw: 4'b0000, downsample: 5'd1};
		for (int i = 0; i < 100 && rstN !== 1'b1; i++) @(posedge clk);
		if (rstN !== 1'b1) begin
			otherErrors++;
			$display("reset was never released");
		end
		@(negedge clk);
		idAssignment();
		argumentCommands();
		channelToggles();
		pwmDuty();
		tdcReadout();
		chainControl();
		$display("errors: %0d mismatches, %0d other failures", mismatchErrors, otherErrors);
		if (mismatchErrors + otherErrors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// guard against a stuck run
	initial begin
		#200us;
		$display("run exceeded its time limit");
		$display("Regression failed");
		$finish;
	end

endmodule

/* verification/tbClock.sv */
// 10 ns clock from time zero; rstN held low for 16 rising edges, then released on an edge
`timescale 1ns/1ps

module tbClock (
	output logic clk,
	output logic rstN
);
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 100 MHz
	end

	initial begin
		rstN = 1'b0;
		repeat (16) @(posedge clk);
		rstN <= 1'b1; // release in step with the stimulus
	end

endmodule

/* verilog/cfgPkg.sv */
// board configuration word and its power-up values; triggerPoint and triggerTot live outside it
package cfgPkg;

	typedef logic [7:0] pwmLevel_t; // duty in 1/256 steps
	typedef pwmLevel_t [3:0] pwmLevels_t; // index is channel

	typedef struct packed {
		logic [7:0] boardId;
		logic [1:0] masterClock; // 00 own master, 01 slave
		logic imTheLast; // last board in the chain
		logic serialPassthrough; // another board owns the reply line
		logic rollingTrigger;
		logic [7:0] trigThresh;
		logic [7:0] trigThresh2; // must stay below this to trigger
		logic [3:0] triggerType; // bit0 rising edge
		logic [3:0] trigChannels; // per channel trigger enable
		logic [3:0] gainSw; // 1 selects the high gain resistor
		logic [4:0] downsample; // log2 of sample skip, max 30
	} scopeCfg_t;

	localparam scopeCfg_t cfgReset = '{
		boardId: 8'd200, // no id until the chain assigns one
		masterClock: 2'b00,
		imTheLast: 1'b0,
		serialPassthrough: 1'b0,
		rollingTrigger: 1'b1,
		trigThresh: 8'h80,
		trigThresh2: 8'hFF,
		triggerType: 4'b0001,
		trigChannels: 4'b1111,
		gainSw: 4'b0000,
		downsample: 5'd1
	};

	localparam pwmLevel_t pwmResetLevel = 8'd58; // about 23 percent duty
	localparam pwmLevels_t levelsReset = {4{pwmResetLevel}};

endpackage

/* verilog/cmdPkg.sv */
// command bytes and request strobes for the chain; argument counts cover only the kept opcodes
package cmdPkg;

	typedef logic [7:0] cmdByte_t; // one serial byte

	localparam cmdByte_t idBase = 8'd0; // 0-9 assign board id
	localparam cmdByte_t selectBase = 8'd10; // 10-19 pick board for readout
	localparam cmdByte_t lastBase = 8'd20; // 20-29 mark end of chain
	localparam cmdByte_t opArm = 8'd100;
	localparam cmdByte_t opRollOn = 8'd101;
	localparam cmdByte_t opRollOff = 8'd102;
	localparam cmdByte_t opSetTrigPoint = 8'd121; // 2 args, high byte first
	localparam cmdByte_t opDownsample = 8'd124;
	localparam cmdByte_t opTrigThresh = 8'd127;
	localparam cmdByte_t opTrigType = 8'd128;
	localparam cmdByte_t opTrigTot = 8'd129; // 2 args
	localparam cmdByte_t opTrigChan = 8'd130;
	localparam cmdByte_t opDelayCnt = 8'd132;
	localparam cmdByte_t opCarryCnt = 8'd133;
	localparam cmdByte_t opGainSw = 8'd134;
	localparam cmdByte_t opPwmLevel = 8'd135; // 2 args, channel then level
	localparam cmdByte_t opTrigThresh2 = 8'd140;

	// extra bytes that follow an opcode, unknown codes take none
	function automatic logic [1:0] argCountOf(cmdByte_t op);
		case (op)
			opSetTrigPoint, opTrigTot, opPwmLevel: return 2'd2;
			opDownsample, opTrigThresh, opTrigType, opTrigChan, opGainSw,
			opTrigThresh2: return 2'd1;
			default: return 2'd0;
		endcase
	endfunction

	typedef struct packed {
		logic valid; // one cycle per complete command
		cmdByte_t opcode;
		cmdByte_t arg0; // first argument, high byte of a word
		cmdByte_t arg1;
	} cmdFrame_t;

	typedef struct packed {
		logic valid;
		cmdByte_t data; // byte for the next board
	} fwdReq_t;

	typedef struct packed {
		logic valid;
		logic useCarry; // 0 sends delay counter
	} tdcReq_t;

	typedef struct packed {
		logic [5:0] board;
		logic [1:0] chan;
	} chanSelFields_t;

	// channel argument seen as a byte or as board*4+chan
	typedef union packed {
		cmdByte_t raw;
		chanSelFields_t sel;
	} chanSel_u;

endpackage

/* verilog/cmdReceiver.sv */
// needs bytes at least 4 clocks apart; opcode bytes of unknown commands are taken as zero-argument
`timescale 1ns/1ps

module cmdReceiver (
	input logic clk,
	input logic rstN,
	input logic rxReady, // one cycle per received byte
	input cmdPkg::cmdByte_t rxData,
	input cmdPkg::fwdReq_t fwd, // decided forwards from the config block
	output cmdPkg::cmdFrame_t frame,
	output cmdPkg::cmdByte_t comData,
	output logic newComData
);
	import cmdPkg::*;

	typedef enum logic {stIdle, stArgs} rxState_t;

	rxState_t state;
	cmdByte_t opcode; // opcode waiting for its arguments
	cmdByte_t firstArg;
	logic [1:0] argsWanted;
	logic [1:0] argsSeen;
	logic [1:0] rxArgCount;
	logic lastArg;

	assign rxArgCount = argCountOf(rxData);
	assign lastArg = (argsSeen + 2'd1) == argsWanted; // this byte completes the command

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= stIdle;
			argsWanted <= '0;
			argsSeen <= '0;
			frame <= '0;
			comData <= '0;
			newComData <= 1'b0;
		end else begin
			frame.valid <= 1'b0; // frames are single pulses
			newComData <= 1'b0;
			if (fwd.valid) begin
				comData <= fwd.data; // zero-argument forward, one cycle late
				newComData <= 1'b1;
			end
			if (rxReady) begin
				case (state)
					stIdle: begin
						if (rxArgCount == 2'd0) begin
							frame <= '{valid: 1'b1, opcode: rxData, arg0: '0, arg1: '0};
						end else begin
							comData <= rxData; // argument opcodes always go down the chain
							newComData <= 1'b1;
							argsWanted <= rxArgCount;
							argsSeen <= '0;
							state <= stArgs;
						end
					end
					stArgs: begin
						comData <= rxData; // arguments too
						newComData <= 1'b1;
						argsSeen <= argsSeen + 2'd1;
						if (lastArg) begin
							state <= stIdle;
							if (argsSeen == 2'd0) begin
								frame <= '{valid: 1'b1, opcode: opcode, arg0: rxData, arg1: '0};
							end else begin
								frame <= '{valid: 1'b1, opcode: opcode, arg0: firstArg,
									arg1: rxData};
							end
						end
					end
					default: state <= stIdle;
				endcase
			end
		end
	end

	// command bytes kept for frame assembly
	always_ff @(posedge clk) begin
		if (rxReady && state == stIdle) opcode <= rxData;
		if (rxReady && state == stArgs && argsSeen == 2'd0) firstArg <= rxData;
	end

	// downstream applies each frame once
	frameOneCycle: assert property (@(posedge clk) disable iff (!rstN)
		frame.valid |=> !frame.valid);

endmodule

/* verilog/offsetPwm.sv */
// counter steps every pwmPrescale+1 clocks, so one PWM period is 256*(pwmPrescale+1) clocks
`timescale 1ns/1ps

module offsetPwm #(
	parameter int pwmPrescale = 2 // extra clocks per counter step
) (
	input logic clk,
	input logic rstN,
	input cfgPkg::pwmLevels_t levels,
	output logic [3:0] offset // to the RC filters of the offset DACs
);
	import cfgPkg::*;

	localparam int preW = (pwmPrescale > 0) ? $clog2(pwmPrescale + 1) : 1;
	localparam logic [preW-1:0] preLast = preW'(pwmPrescale);

	logic [preW-1:0] preCount;
	pwmLevel_t pwmCount; // free running

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			preCount <= '0;
			pwmCount <= '0;
		end else if (preCount == preLast) begin
			preCount <= '0;
			pwmCount <= pwmCount + 8'd1; // wraps at 256
		end else begin
			preCount <= preCount + 1'b1;
		end
	end

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			offset[i] = levels[i] > pwmCount; // high for level counts of each period
		end
	end

endmodule

/* verilog/scopeConfigRegs.sv */
// applies one frame per pulse; two-byte values are high byte first and need ramWidth up to 15
`timescale 1ns/1ps

module scopeConfigRegs #(
	parameter int ramWidth = 12 // log2 of sample memory depth
) (
	input logic clk,
	input logic rstN,
	input cmdPkg::cmdFrame_t frame,
	output cfgPkg::scopeCfg_t cfg,
	output logic [ramWidth-1:0] triggerPoint,
	output logic [ramWidth:0] triggerTot,
	output cfgPkg::pwmLevels_t levels,
	output logic armTrigger, // one cycle
	output cmdPkg::fwdReq_t fwd,
	output cmdPkg::tdcReq_t tdcReq
);
	import cmdPkg::*;
	import cfgPkg::*;

	localparam int pointMin = 4;
	localparam int pointMax = 2 ** ramWidth - 16; // keep room for post-trigger samples
	localparam logic [ramWidth-1:0] pointReset = ramWidth'(2 ** (ramWidth - 2)); // quarter depth

	logic [15:0] argWord;
	logic [ramWidth-1:0] clampedPoint;
	logic [4:0] clampedDownsample;
	cmdByte_t selOffset;
	cmdByte_t lastOffset;
	chanSel_u chanSel;
	logic chanIsMine;

	assign argWord = {frame.arg0, frame.arg1};
	assign selOffset = frame.opcode - selectBase; // board named by a select byte
	assign lastOffset = frame.opcode - lastBase;
	assign chanSel.raw = frame.arg0;
	assign chanIsMine = {2'b00, chanSel.sel.board} == cfg.boardId;
	assign clampedDownsample = (frame.arg0 > 8'd30) ? 5'd30 : frame.arg0[4:0];

	always_comb begin
		if (argWord > pointMax) clampedPoint = ramWidth'(pointMax);
		else if (argWord < pointMin) clampedPoint = ramWidth'(pointMin);
		else clampedPoint = argWord[ramWidth-1:0];
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			cfg <= cfgReset;
			triggerPoint <= pointReset;
			triggerTot <= '0;
			levels <= levelsReset;
			armTrigger <= 1'b0;
			fwd <= '0;
			tdcReq <= '0;
		end else begin
			armTrigger <= 1'b0;
			fwd.valid <= 1'b0;
			tdcReq.valid <= 1'b0;
			if (frame.valid) begin
				case (frame.opcode) inside
					[idBase:idBase + 8'd9]: begin
						cfg.boardId <= frame.opcode - idBase;
						cfg.masterClock <= (frame.opcode == idBase) ? 2'b00 : 2'b01; // id 0 drives clock
						fwd <= '{valid: 1'b1, data: frame.opcode + 8'd1}; // next board gets id+1
					end
					[selectBase:selectBase + 8'd9]: begin
						if (selOffset == cfg.boardId) begin
							cfg.serialPassthrough <= 1'b0; // we answer
						end else begin
							cfg.serialPassthrough <= 1'b1;
							fwd <= '{valid: 1'b1, data: frame.opcode};
						end
					end
					[lastBase:lastBase + 8'd9]: begin
						cfg.imTheLast <= lastOffset == cfg.boardId;
						fwd <= '{valid: 1'b1, data: frame.opcode};
					end
					opArm: begin
						armTrigger <= 1'b1;
						fwd <= '{valid: 1'b1, data: frame.opcode};
					end
					opRollOn, opRollOff: begin
						cfg.rollingTrigger <= frame.opcode == opRollOn;
						fwd <= '{valid: 1'b1, data: frame.opcode};
					end
					opDelayCnt, opCarryCnt: begin
						if (cfg.serialPassthrough) begin
							fwd <= '{valid: 1'b1, data: frame.opcode}; // selected board is further on
						end else begin
							tdcReq <= '{valid: 1'b1, useCarry: frame.opcode == opCarryCnt};
						end
					end
					opSetTrigPoint: triggerPoint <= clampedPoint;
					opDownsample: cfg.downsample <= clampedDownsample;
					opTrigThresh: cfg.trigThresh <= frame.arg0;
					opTrigThresh2: cfg.trigThresh2 <= frame.arg0;
					opTrigType: cfg.triggerType <= frame.arg0[3:0];
					opTrigTot: triggerTot <= argWord[ramWidth:0];
					opTrigChan: begin
						if (chanIsMine) begin
							cfg.trigChannels[chanSel.sel.chan] <= ~cfg.trigChannels[chanSel.sel.chan];
						end
					end
					opGainSw: begin
						if (chanIsMine) cfg.gainSw[chanSel.sel.chan] <= ~cfg.gainSw[chanSel.sel.chan];
					end
					opPwmLevel: begin
						if (chanIsMine) levels[chanSel.sel.chan] <= frame.arg1;
					end
					default: ; // ignored, not forwarded
				endcase
			end
		end
	end

	// the capture address math downstream relies on this window
	trigPointInRange: assert property (@(posedge clk) disable iff (!rstN)
		triggerPoint >= pointMin && triggerPoint <= pointMax);

	// a reply and a forward would both claim the same command byte
	fwdOrReply: assert property (@(posedge clk) disable iff (!rstN)
		!(fwd.valid && tdcReq.valid));

endmodule

/* verilog/scopeController.sv */
// command side only; serial bytes must be at least 4 clocks apart, chain forward has no back-pressure
`timescale 1ns/1ps

module scopeController #(
	parameter int ramWidth = 12, // sample memory address bits
	parameter int pwmPrescale = 2
) (
	input logic clk,
	input logic rstN,
	input logic rxReady,
	input cmdPkg::cmdByte_t rxData,
	input logic txBusy,
	input logic [7:0] delayCounter, // TDC results
	input logic [7:0] carryCounter,
	output logic txStart,
	output cmdPkg::cmdByte_t txData,
	output cmdPkg::cmdByte_t comData, // to next board
	output logic newComData,
	output cfgPkg::scopeCfg_t cfg,
	output logic [ramWidth-1:0] triggerPoint,
	output logic [ramWidth:0] triggerTot,
	output logic armTrigger,
	output logic [3:0] offset
);
	import cmdPkg::*;
	import cfgPkg::*;

	cmdFrame_t frame;
	fwdReq_t fwd;
	tdcReq_t tdcReq;
	pwmLevels_t levels;

	cmdReceiver cmdReceiver_inst (
		.clk(clk), .rstN(rstN), .rxReady(rxReady), .rxData(rxData), .fwd(fwd),
		.frame(frame), .comData(comData), .newComData(newComData)
	);

	scopeConfigRegs #(.ramWidth(ramWidth)) scopeConfigRegs_inst (
		.clk(clk), .rstN(rstN), .frame(frame), .cfg(cfg), .triggerPoint(triggerPoint),
		.triggerTot(triggerTot), .levels(levels), .armTrigger(armTrigger), .fwd(fwd),
		.tdcReq(tdcReq)
	);

	offsetPwm #(.pwmPrescale(pwmPrescale)) offsetPwm_inst (
		.clk(clk), .rstN(rstN), .levels(levels), .offset(offset)
	);

	tdcReply tdcReply_inst (
		.clk(clk), .rstN(rstN), .tdcReq(tdcReq), .delayCounter(delayCounter),
		.carryCounter(carryCounter), .txBusy(txBusy), .txStart(txStart), .txData(txData)
	);

endmodule

/* verilog/tdcReply.sv */
// one byte per request; new requests are dropped while a byte waits on txBusy
`timescale 1ns/1ps

module tdcReply (
	input logic clk,
	input logic rstN,
	input cmdPkg::tdcReq_t tdcReq,
	input logic [7:0] delayCounter,
	input logic [7:0] carryCounter,
	input logic txBusy, // UART still shifting
	output logic txStart,
	output cmdPkg::cmdByte_t txData
);
	logic pending; // byte latched, transmitter busy
	logic accept;

	assign accept = tdcReq.valid && !pending;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pending <= 1'b0;
			txStart <= 1'b0;
		end else begin
			txStart <= 1'b0;
			if (accept) begin
				if (txBusy) pending <= 1'b1;
				else txStart <= 1'b1; // straight out when idle
			end else if (pending && !txBusy) begin
				txStart <= 1'b1;
				pending <= 1'b0;
			end
		end
	end

	// counter sampled at request time and held until sent
	always_ff @(posedge clk) begin
		if (accept) txData <= tdcReq.useCarry ? carryCounter : delayCounter;
	end

	// UART takes one start strobe per byte
	txStartPulse: assert property (@(posedge clk) disable iff (!rstN)
		txStart |=> !txStart);

endmodule
